// File: list.f
+incdir+include
design/starPkg.sv
design/flitFifo.sv
design/leafRouter.sv
design/hubRouter.sv
design/starNetwork.sv
dv/starChecker.sv
dv/starTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module starTb -o simStar
./obj_dir/simStar | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation clean"

// File: dv/starTb.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module starTb;

  localparam int N               = `NUM_LEAVES;
  localparam int TRAFFIC_TIMEOUT = 5000;
  localparam int DRAIN_TIMEOUT   = 2000;
  localparam int IDLE_CYCLES     = 50;
  localparam int MODE_ALL_PAIRS  = 0;
  localparam int MODE_RANDOM     = 1;
  localparam int MODE_HOTSPOT    = 2;

  logic             clk;
  logic             rstN;
  logic [N-1:0]     injValid;
  starPkg::leafIdT  injDest [N];
  starPkg::payloadT injData [N];
  logic [N-1:0]     injReady;
  logic [N-1:0]     ejValid;
  starPkg::leafIdT  ejSrc [N];
  starPkg::payloadT ejData [N];
  logic [N-1:0]     ejReady;

  int               injCount;
  int               ejCount;
  int               pendingCount;
  int               chkErrors;
  int               tbErrors;
  logic [31:0]      rngState;
  int               remaining [N];
  int               stallLeft [N];
  logic             sawInjStall;

  starNetwork UUT (
    .clk(clk), .rstN(rstN),
    .injValid(injValid), .injDest(injDest), .injData(injData), .injReady(injReady),
    .ejValid(ejValid), .ejSrc(ejSrc), .ejData(ejData), .ejReady(ejReady)
  );

  starChecker chk (
    .clk(clk), .rstN(rstN),
    .injValid(injValid), .injDest(injDest), .injData(injData), .injReady(injReady),
    .ejValid(ejValid), .ejSrc(ejSrc), .ejData(ejData), .ejReady(ejReady),
    .injCount(injCount), .ejCount(ejCount), .pendingCount(pendingCount),
    .errCount(chkErrors)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // Eject ready with occasional long stalls
  function automatic logic nextReady(input int i);
    logic [31:0] r;
    r = nextRand();
    if (stallLeft[i] > 0)
    begin
      stallLeft[i]--;
      return 1'b0;
    end
    if (r[2:0] == 3'b000)
    begin
      stallLeft[i] = 8 + int'(r[7:3]);
      return 1'b0;
    end
    return r[9:8] != 2'b00;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  // Sample handshakes at the edge, then drive 2 ns later
  task automatic stepCycle(input int mode, input bit bpOn);
    logic [N-1:0] fired;
    logic [31:0]  r;
    @(posedge clk);
    fired = injValid & injReady;
    if (|(injValid & ~injReady))
      sawInjStall = 1'b1;
    #2;
    for (int i = 0; i < N; i++)
    begin
      if (fired[i])
      begin
        remaining[i]--;
        injValid[i] = 1'b0;
      end
      r = nextRand();
      if (!injValid[i] && remaining[i] > 0 && r[1:0] != 2'b00)
      begin
        injValid[i] = 1'b1;
        injData[i]  = starPkg::payloadT'(r[31:8]);
        case (mode)
          MODE_ALL_PAIRS: injDest[i] = starPkg::leafIdT'(N - remaining[i]);
          MODE_HOTSPOT:   injDest[i] = '0;
          default:        injDest[i] = starPkg::leafIdT'(int'(r[7:2]) % N);
        endcase
      end
      ejReady[i] = bpOn ? nextReady(i) : 1'b1;
    end
  endtask

  // With round-robin sharing no leaf lags far behind the first one to finish
  task automatic checkStarvation(input string name, input int perLeaf);
    for (int i = 0; i < N; i++)
      if (remaining[i] > perLeaf / 2)
      begin
        $display("Test %s: leaf %0d starved with %0d of %0d flits unsent",
                 name, i, remaining[i], perLeaf);
        tbErrors++;
      end
  endtask

  task automatic runTraffic(input string name, input int mode, input int perLeaf,
                            input bit bpOn);
    int cycles;
    int errBefore;
    int startInj;
    bit busy;
    bit shareChecked;
    errBefore    = tbErrors + chkErrors;
    startInj     = injCount;
    sawInjStall  = 1'b0;
    shareChecked = (mode != MODE_HOTSPOT);
    for (int i = 0; i < N; i++)
      remaining[i] = perLeaf;
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < TRAFFIC_TIMEOUT)
    begin
      stepCycle(mode, bpOn);
      cycles++;
      busy = 1'b0;
      for (int i = 0; i < N; i++)
        if (remaining[i] > 0)
          busy = 1'b1;
      if (!shareChecked)
        for (int i = 0; i < N; i++)
          if (remaining[i] == 0 && !shareChecked)
          begin
            checkStarvation(name, perLeaf);
            shareChecked = 1'b1;
          end
    end
    if (busy)
    begin
      $display("Test %s: timed out with flits still waiting to be injected", name);
      tbErrors++;
    end
    cycles = 0;
    while (pendingCount != 0 && cycles < DRAIN_TIMEOUT)
    begin
      stepCycle(mode, bpOn);
      cycles++;
    end
    if (pendingCount != 0)
    begin
      $display("Test %s: timed out with %0d flits never delivered", name, pendingCount);
      tbErrors++;
    end
    if (bpOn && !sawInjStall)
    begin
      $display("Test %s: injReady never went low under back-pressure", name);
      tbErrors++;
    end
    ejReady = '1;
    $display("Test %s: finished, %0d flits, %0d new errors",
             name, injCount - startInj, tbErrors + chkErrors - errBefore);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed checks

  task automatic checkReset();
    for (int i = 0; i < N; i++)
    begin
      if (ejValid[i] !== 1'b0)
      begin
        $display("[ERROR] %0d ns: ejValid[%0d] expected 0, got %b", $time, i, ejValid[i]);
        tbErrors++;
      end
      if (injReady[i] !== 1'b1)
      begin
        $display("[ERROR] %0d ns: injReady[%0d] expected 1, got %b", $time, i, injReady[i]);
        tbErrors++;
      end
    end
    $display("Test reset: finished, %0d errors", tbErrors);
  endtask

  task automatic checkDrain();
    int errBefore;
    errBefore = tbErrors + chkErrors;
    if (injCount != ejCount)
    begin
      $display("[ERROR] %0d ns: delivered count expected %0d, got %0d",
               $time, injCount, ejCount);
      tbErrors++;
    end
    injValid = '0;
    ejReady  = '1;
    for (int c = 0; c < IDLE_CYCLES; c++)
    begin
      @(posedge clk);
      if (ejValid != '0)
      begin
        $display("Idle stretch: ejValid rose with no traffic at %0d ns", $time);
        tbErrors++;
      end
    end
    $display("Test drain: finished, %0d new errors", tbErrors + chkErrors - errBefore);
  endtask

  initial
  begin
    clk         = 1'b0;
    rstN        = 1'b0;
    injValid    = '0;
    ejReady     = '1;
    rngState    = 32'h0ed9_b15a;
    tbErrors    = 0;
    sawInjStall = 1'b0;
    for (int i = 0; i < N; i++)
    begin
      injDest[i]   = '0;
      injData[i]   = '0;
      remaining[i] = 0;
      stallLeft[i] = 0;
    end
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;

    checkReset();
    runTraffic("allPairs", MODE_ALL_PAIRS, N, 1'b0);
    runTraffic("random", MODE_RANDOM, 60, 1'b0);
    runTraffic("backPressure", MODE_RANDOM, 60, 1'b1);
    runTraffic("hotspot", MODE_HOTSPOT, 40, 1'b0);
    checkDrain();

    $display("Summary: %0d injected, %0d delivered, %0d errors",
             injCount, ejCount, tbErrors + chkErrors);
    if (tbErrors + chkErrors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: dv/starChecker.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module starChecker (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`NUM_LEAVES-1:0] injValid,
  input  starPkg::leafIdT        injDest [`NUM_LEAVES],
  input  starPkg::payloadT       injData [`NUM_LEAVES],
  input  logic [`NUM_LEAVES-1:0] injReady,
  input  logic [`NUM_LEAVES-1:0] ejValid,
  input  starPkg::leafIdT        ejSrc [`NUM_LEAVES],
  input  starPkg::payloadT       ejData [`NUM_LEAVES],
  input  logic [`NUM_LEAVES-1:0] ejReady,
  output int                     injCount,
  output int                     ejCount,
  output int                     pendingCount,
  output int                     errCount
);

  localparam int N = `NUM_LEAVES;

  // One queue of expected payloads per (source, dest) pair, key is src*N+dest
  starPkg::payloadT expQ [N*N][$];

  always @(posedge clk)
  begin
    int               key;
    starPkg::payloadT expVal;
    if (!rstN)
    begin
      injCount     = 0;
      ejCount      = 0;
      pendingCount = 0;
      errCount     = 0;
      for (int k = 0; k < N*N; k++)
        expQ[k].delete();
    end
    else
    begin
      for (int s = 0; s < N; s++)
        if (injValid[s] && injReady[s])
        begin
          key = s * N + int'(injDest[s]);
          expQ[key].push_back(injData[s]);
          injCount++;
          pendingCount++;
        end
      for (int d = 0; d < N; d++)
        if (ejValid[d] && ejReady[d])
        begin
          ejCount++;
          key = int'(ejSrc[d]) * N + d;
          if (int'(ejSrc[d]) >= N || expQ[key].size() == 0)
          begin
            $display("Leaf %0d ejected a flit from leaf %0d that was never sent to it, at %0d ns",
                     d, ejSrc[d], $time);
            errCount++;
          end
          else
          begin
            expVal = expQ[key].pop_front();
            pendingCount--;
            if (ejData[d] !== expVal)
            begin
              $display("[ERROR] %0d ns: ejData[%0d] expected 0x%02h, got 0x%02h",
                       $time, d, expVal, ejData[d]);
              errCount++;
            end
          end
        end
    end
  end

endmodule

// File: design/starNetwork.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module starNetwork (
  input  logic                   clk,
  input  logic                   rstN,
  // Local inject ports
  input  logic [`NUM_LEAVES-1:0] injValid,
  input  starPkg::leafIdT        injDest [`NUM_LEAVES],
  input  starPkg::payloadT       injData [`NUM_LEAVES],
  output logic [`NUM_LEAVES-1:0] injReady,
  // Local eject ports
  output logic [`NUM_LEAVES-1:0] ejValid,
  output starPkg::leafIdT        ejSrc [`NUM_LEAVES],
  output starPkg::payloadT       ejData [`NUM_LEAVES],
  input  logic [`NUM_LEAVES-1:0] ejReady
);

  // Leaf to hub links
  logic [`NUM_LEAVES-1:0] upValid;
  starPkg::flitT          upFlit [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] upReady;

  // Hub to leaf links
  logic [`NUM_LEAVES-1:0] downValid;
  starPkg::flitT          downFlit [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] downReady;

  hubRouter hub (
    .clk      (clk),
    .rstN     (rstN),
    .upValid  (upValid),
    .upFlit   (upFlit),
    .upReady  (upReady),
    .downValid(downValid),
    .downFlit (downFlit),
    .downReady(downReady)
  );

  for (genvar i = 0; i < `NUM_LEAVES; i++)
  begin : gLeaf
    leafRouter #(.LEAF_ID(i)) leaf (
      .clk      (clk),
      .rstN     (rstN),
      .injValid (injValid[i]),
      .injDest  (injDest[i]),
      .injData  (injData[i]),
      .injReady (injReady[i]),
      .ejValid  (ejValid[i]),
      .ejSrc    (ejSrc[i]),
      .ejData   (ejData[i]),
      .ejReady  (ejReady[i]),
      .upValid  (upValid[i]),
      .upFlit   (upFlit[i]),
      .upReady  (upReady[i]),
      .downValid(downValid[i]),
      .downFlit (downFlit[i]),
      .downReady(downReady[i])
    );
  end

endmodule

// File: design/hubRouter.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module hubRouter (
  input  logic                    clk,
  input  logic                    rstN,
  // Uplinks, one per leaf
  input  logic [`NUM_LEAVES-1:0]  upValid,
  input  starPkg::flitT           upFlit [`NUM_LEAVES],
  output logic [`NUM_LEAVES-1:0]  upReady,
  // Downlinks, one per leaf
  output logic [`NUM_LEAVES-1:0]  downValid,
  output starPkg::flitT           downFlit [`NUM_LEAVES],
  input  logic [`NUM_LEAVES-1:0]  downReady
);

  // Input side
  logic [`NUM_LEAVES-1:0] headValid;
  starPkg::flitT          headFlit [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] headPop;

  // Arbitration, grant[o][i] means input i wins output o
  logic [`NUM_LEAVES-1:0] grant [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] grantCol [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] grantAny;
  starPkg::leafIdT        grantIdx [`NUM_LEAVES];
  starPkg::leafIdT        rrPtr [`NUM_LEAVES];
  logic [`NUM_LEAVES-1:0] outFree;

  ////////////////////////////////////////////////////////////////////////////
  // Input queues

  for (genvar i = 0; i < `NUM_LEAVES; i++)
  begin : gInput
    flitFifo #(.DEPTH(`FIFO_DEPTH)) inFifo (
      .clk      (clk),
      .rstN     (rstN),
      .pushValid(upValid[i]),
      .pushFlit (upFlit[i]),
      .pushReady(upReady[i]),
      .popValid (headValid[i]),
      .popFlit  (headFlit[i]),
      .popReady (headPop[i])
    );

    assign headPop[i] = |grantCol[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin arbiters

  // Output register can take a flit if empty or draining now
  assign outFree = ~downValid | downReady;

  always_comb
  begin
    int   idx;
    logic found;
    for (int o = 0; o < `NUM_LEAVES; o++)
    begin
      grant[o]    = '0;
      grantIdx[o] = '0;
      found       = 1'b0;
      // Scan starting at the pointer, first match wins
      for (int k = 0; k < `NUM_LEAVES; k++)
      begin
        idx = (int'(rrPtr[o]) + k) % `NUM_LEAVES;
        if (!found && outFree[o] && headValid[idx] &&
            headFlit[idx].dest == starPkg::leafIdT'(o))
        begin
          grant[o][idx] = 1'b1;
          grantIdx[o]   = starPkg::leafIdT'(idx);
          found         = 1'b1;
        end
      end
      grantAny[o] = found;
    end
  end

  // Transpose so each input sees its grants
  always_comb
  begin
    for (int i = 0; i < `NUM_LEAVES; i++)
      for (int o = 0; o < `NUM_LEAVES; o++)
        grantCol[i][o] = grant[o][i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      downValid <= '0;
      for (int o = 0; o < `NUM_LEAVES; o++)
        rrPtr[o] <= '0;
    end
    else
    begin
      for (int o = 0; o < `NUM_LEAVES; o++)
      begin
        if (grantAny[o])
        begin
          downValid[o] <= 1'b1;
          // Winner goes to the back of the line
          rrPtr[o] <= (int'(grantIdx[o]) == `NUM_LEAVES - 1) ? '0 : grantIdx[o] + 1'b1;
        end
        else if (downReady[o])
          downValid[o] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < `NUM_LEAVES; o++)
      if (grantAny[o])
        downFlit[o] <= headFlit[grantIdx[o]];
  end

  for (genvar n = 0; n < `NUM_LEAVES; n++)
  begin : gCheck
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant[n]))
      else $error("hubRouter: output %0d granted to several inputs", n);
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(grantCol[n]))
      else $error("hubRouter: input %0d granted to several outputs", n);
  end

endmodule

// File: design/leafRouter.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module leafRouter #(
  parameter int LEAF_ID = 0
) (
  input  logic             clk,
  input  logic             rstN,
  // Local client, inject side
  input  logic             injValid,
  input  starPkg::leafIdT  injDest,
  input  starPkg::payloadT injData,
  output logic             injReady,
  // Local client, eject side
  output logic             ejValid,
  output starPkg::leafIdT  ejSrc,
  output starPkg::payloadT ejData,
  input  logic             ejReady,
  // Link toward the hub
  output logic             upValid,
  output starPkg::flitT    upFlit,
  input  logic             upReady,
  // Link from the hub
  input  logic             downValid,
  input  starPkg::flitT    downFlit,
  output logic             downReady
);

  starPkg::flitT injFlit;
  starPkg::flitT ejFlit;

  ////////////////////////////////////////////////////////////////////////////
  // Inject path

  // Source id stamped here
  assign injFlit = '{dest: injDest, src: starPkg::leafIdT'(LEAF_ID), payload: injData};

  flitFifo #(.DEPTH(`FIFO_DEPTH)) injFifo (
    .clk      (clk),
    .rstN     (rstN),
    .pushValid(injValid),
    .pushFlit (injFlit),
    .pushReady(injReady),
    .popValid (upValid),
    .popFlit  (upFlit),
    .popReady (upReady)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Eject path

  flitFifo #(.DEPTH(`FIFO_DEPTH)) ejFifo (
    .clk      (clk),
    .rstN     (rstN),
    .pushValid(downValid),
    .pushFlit (downFlit),
    .pushReady(downReady),
    .popValid (ejValid),
    .popFlit  (ejFlit),
    .popReady (ejReady)
  );

  assign ejSrc  = ejFlit.src;
  assign ejData = ejFlit.payload;

  assert property (@(posedge clk) disable iff (!rstN)
    (injValid && injReady) |-> (int'(injDest) < `NUM_LEAVES))
    else $error("leafRouter %0d: inject to missing leaf %0d", LEAF_ID, injDest);

  // Hub routing must land every flit at its own dest
  assert property (@(posedge clk) disable iff (!rstN)
    (downValid && downReady) |-> (downFlit.dest == starPkg::leafIdT'(LEAF_ID)))
    else $error("leafRouter %0d: misrouted flit for %0d", LEAF_ID, downFlit.dest);

endmodule

// File: design/flitFifo.sv
`timescale 1ns/10ps
`include "star_settings.svh"

module flitFifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          pushValid,
  input  starPkg::flitT pushFlit,
  output logic          pushReady,
  output logic          popValid,
  output starPkg::flitT popFlit,
  input  logic          popReady
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  starPkg::flitT   mem [DEPTH];
  logic [ADDR_W:0] wrPtr;
  logic [ADDR_W:0] rdPtr;
  logic [ADDR_W:0] count;
  logic            full;
  logic            empty;

  // Step a pointer, flipping the wrap bit at the last entry
  function automatic logic [ADDR_W:0] nextPtr(input logic [ADDR_W:0] ptr);
    if (ptr[ADDR_W-1:0] == ADDR_W'(DEPTH - 1))
      return {~ptr[ADDR_W], {ADDR_W{1'b0}}};
    return ptr + 1'b1;
  endfunction

  assign empty     = (wrPtr == rdPtr);
  assign full      = (wrPtr[ADDR_W-1:0] == rdPtr[ADDR_W-1:0]) && (wrPtr[ADDR_W] != rdPtr[ADDR_W]);
  assign pushReady = !full;
  assign popValid  = !empty;
  assign popFlit   = mem[rdPtr[ADDR_W-1:0]];

  // Occupancy, used only by the checks below
  always_comb
  begin
    if (wrPtr[ADDR_W] == rdPtr[ADDR_W])
      count = wrPtr - rdPtr;
    else
      count = (ADDR_W+1)'(DEPTH) + {1'b0, wrPtr[ADDR_W-1:0]} - {1'b0, rdPtr[ADDR_W-1:0]};
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (pushValid && pushReady)
        wrPtr <= nextPtr(wrPtr);
      if (popValid && popReady)
        rdPtr <= nextPtr(rdPtr);
    end
  end

  always_ff @(posedge clk)
  begin
    if (pushValid && pushReady)
      mem[wrPtr[ADDR_W-1:0]] <= pushFlit;
  end

  // While full, the write side must not move on the next edge
  assert property (@(posedge clk) disable iff (!rstN) full |=> $stable(wrPtr))
    else $error("flitFifo: write while full");

  assert property (@(posedge clk) disable iff (!rstN) count <= (ADDR_W+1)'(DEPTH))
    else $error("flitFifo: occupancy %0d above depth", count);

endmodule

// File: design/starPkg.sv
`include "star_settings.svh"

package starPkg;

  localparam int LEAF_ID_W = (`NUM_LEAVES > 1) ? $clog2(`NUM_LEAVES) : 1;

  typedef logic [LEAF_ID_W-1:0] leafIdT;
  typedef logic [`DATA_WIDTH-1:0] payloadT;

  // Single-flit packet, routed on dest
  typedef struct packed {
    leafIdT  dest;
    leafIdT  src;
    payloadT payload;
  } flitT;

endpackage

// File: include/star_settings.svh
`ifndef STAR_SETTINGS_SVH
`define STAR_SETTINGS_SVH

// Leaf routers hanging off the hub
`define NUM_LEAVES 4

// Payload bits per flit
`define DATA_WIDTH 8

// Entries in every flit queue
`define FIFO_DEPTH 4

`endif
